// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - ctrl_if.sv
  - control.sv
  - rf_bypassed.sv
  - decode.sv
  - stage_reg.sv
  - decode_stage_top.sv
  - target: test
    files:
      - tb_decode_stage.sv

// File: control.sv
`timescale 1ns/1ps
`default_nettype none

module control import cpu_pkg::*; (
    ctrl_if.ctl bus
);
    ctrl_t c;
    logic  bad_op;

    always_comb begin
        c      = '0; // nop-like default, also what an illegal opcode gets
        bad_op = 1'b0;
        case (bus.opcode)
            OP_HALT: c.halt = 1'b1;
            OP_NOP: begin
            end
            OP_SIIC: begin
                c.siic    = 1'b1;
                c.flow_ty = FLOW_JUMP_DIRECT; // target forced to the vector in decode
            end
            OP_RTI: c.rti = 1'b1; // return pc supplied by execute
            OP_J: begin
                c.immcode = IMM_DISPL;
                c.flow_ty = FLOW_JUMP_DIRECT;
            end
            OP_JAL: begin
                c.immcode = IMM_DISPL;
                c.flow_ty = FLOW_JUMP_DIRECT;
                c.link    = 1'b1;
                c.wb_op   = WB_LINK;
                c.rf_wen  = 1'b1;
            end
            OP_JR, OP_JALR: begin
                // target = rs + simm8 through the alu
                c.immcode   = IMM_SIMM8;
                c.alu_op    = ALU_ADD;
                c.alu_b_imm = 1'b1;
                c.flow_ty   = FLOW_JUMP_REG;
                c.link      = bus.opcode[1]; // jalr
                c.rf_wen    = bus.opcode[1];
                c.wb_op     = bus.opcode[1] ? WB_LINK : WB_ALU;
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                c.immcode   = bus.opcode[1] ? IMM_ZIMM5 : IMM_SIMM5; // logic ops zero extend
                c.alu_op    = alu_op_e'({2'b00, bus.opcode[1:0]});
                c.alu_b_imm = 1'b1;
                c.rf_wen    = 1'b1;
            end
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                c.immcode   = IMM_ZIMM5;
                c.alu_op    = alu_op_e'({2'b01, bus.opcode[1:0]});
                c.alu_b_imm = 1'b1;
                c.rf_wen    = 1'b1;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                c.immcode = IMM_SIMM8;
                c.fcu_op  = fcu_op_e'({1'b1, bus.opcode[1:0]}); // vx against zero
                c.flow_ty = FLOW_BRANCH_COND;
            end
            OP_ST: begin
                c.immcode     = IMM_SIMM5;
                c.alu_op      = ALU_ADD;  // address rs + imm
                c.alu_b_imm   = 1'b1;
                c.readfrom_rd = 1'b1;     // store data
                c.dmem_wen    = 1'b1;
            end
            OP_LD: begin
                c.immcode   = IMM_SIMM5;
                c.alu_op    = ALU_ADD;
                c.alu_b_imm = 1'b1;
                c.dmem_ren  = 1'b1;
                c.wb_op     = WB_MEM;
                c.rf_wen    = 1'b1;
            end
            OP_SLBI, OP_LBI: begin
                // both write back into rs, slbi also reads it
                c.immcode    = bus.opcode[3] ? IMM_SIMM8 : IMM_ZIMM8;
                c.alu_op     = bus.opcode[3] ? ALU_PASSB : ALU_SLBI;
                c.alu_b_imm  = 1'b1;
                c.writeto_rs = 1'b1;
                c.rf_wen     = 1'b1;
            end
            OP_SHIFT, OP_ARITH: begin
                c.instr_rformat = 1'b1;
                c.alu_op        = alu_op_e'({1'b0, ~bus.opcode[0], bus.op_ext});
                c.rf_wen        = 1'b1;
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                c.instr_rformat = 1'b1;
                c.fcu_op        = fcu_op_e'({1'b0, bus.opcode[1:0]});
                c.writeflag     = 1'b1;
                c.wb_op         = WB_FLAG; // rd gets 0 or 1
                c.rf_wen        = 1'b1;
            end
            default: bad_op = 1'b1; // stu, btr and holes in the map
        endcase
    end

    assign bus.ctrl = c;
    assign bus.err  = bad_op;

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

    // major opcode, instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_SIIC  = 5'b00010,
        OP_RTI   = 5'b00011,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_ROLI  = 5'b10100,
        OP_SLLI  = 5'b10101,
        OP_RORI  = 5'b10110,
        OP_SRLI  = 5'b10111,
        OP_LBI   = 5'b11000,
        OP_SHIFT = 5'b11010, // rol/sll/ror/srl by op_ext
        OP_ARITH = 5'b11011, // add/sub/xor/andn by op_ext
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // how the immediate field gets widened to a full word
    typedef enum logic [2:0] {
        IMM_ZIMM5 = 3'd0,
        IMM_SIMM5 = 3'd1,
        IMM_ZIMM8 = 3'd2,
        IMM_SIMM8 = 3'd3,
        IMM_DISPL = 3'd4 // 11-bit jump displacement, signed
    } immcode_e;

    // low two bits follow op_ext / opcode[1:0] inside each group
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1, // b - a
        ALU_XOR   = 4'd2,
        ALU_ANDN  = 4'd3, // a & ~b
        ALU_ROL   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_ROR   = 4'd6,
        ALU_SRL   = 4'd7,
        ALU_PASSB = 4'd8, // lbi
        ALU_SLBI  = 4'd9  // (a << 8) | b
    } alu_op_e;

    // compares between two regs, then tests of vx against zero
    typedef enum logic [2:0] {
        FCU_EQ  = 3'd0,
        FCU_LT  = 3'd1,
        FCU_LE  = 3'd2,
        FCU_CO  = 3'd3, // carry out of a + b
        FCU_EQZ = 3'd4,
        FCU_NEZ = 3'd5,
        FCU_LTZ = 3'd6,
        FCU_GEZ = 3'd7
    } fcu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2, // next sequential pc
        WB_FLAG = 2'd3
    } wb_op_e;

    typedef enum logic [1:0] {
        FLOW_SEQ         = 2'd0,
        FLOW_BRANCH_COND = 2'd1,
        FLOW_JUMP_DIRECT = 2'd2, // target is dbranch_tgt
        FLOW_JUMP_REG    = 2'd3  // target comes out of the alu
    } flow_e;

    typedef struct packed {
        logic     instr_rformat; // rd sits in the R-format slot
        logic     writeto_rs;
        logic     readfrom_rd;   // ry from rd, store data
        logic     link;          // write next pc into r7
        immcode_e immcode;
        alu_op_e  alu_op;
        logic     alu_b_imm;     // alu b takes imm16 instead of vy
        fcu_op_e  fcu_op;
        wb_op_e   wb_op;
        logic     writeflag;
        logic     dmem_ren;
        logic     dmem_wen;
        logic     rf_wen;
        flow_e    flow_ty;
        logic     siic;
        logic     rti;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] instr;
        logic [`CPU_DATA_W-1:0] next_pc_basic;
    } ifid_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_REG_W-1:0]  rx;
        logic [`CPU_REG_W-1:0]  ry;
        logic [`CPU_REG_W-1:0]  ro;
        logic [`CPU_DATA_W-1:0] vx;
        logic [`CPU_DATA_W-1:0] vy;
        logic [`CPU_DATA_W-1:0] imm16;
        logic [`CPU_DATA_W-1:0] dbranch_tgt;
        logic                   err;
    } idex_t;

endpackage

`default_nettype wire

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath width, every register and pc is one word
`define CPU_DATA_W 16

// general register file
`define CPU_NREGS 8
`define CPU_REG_W 3

// software interrupt entry point
`define CPU_SIIC_VEC 16'h0002

`endif

// File: ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// opcode fields in, decoded control bundle out, all combinational
interface ctrl_if import cpu_pkg::*; ();
    opcode_e    opcode;
    logic [1:0] op_ext; // instr[1:0], function code of the R-format groups
    ctrl_t      ctrl;
    logic       err;    // opcode not in the table

    modport dec (
        output opcode, op_ext,
        input  ctrl, err
    );

    modport ctl (
        input  opcode, op_ext,
        output ctrl, err
    );
endinterface

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module decode import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_DATA_W-1:0] instr,
    input  logic [`CPU_DATA_W-1:0] next_pc_basic,
    input  logic                   wb_rf_wen, // loopback from MEM/WB
    input  logic [`CPU_REG_W-1:0]  wb_ro,
    input  logic [`CPU_DATA_W-1:0] wb_data,
    output idex_t                  out
);
    ctrl_if cbus ();

    logic [4:0]             imm5;
    logic [7:0]             imm8;
    logic [10:0]            disp11;
    logic [`CPU_REG_W-1:0]  field_rs;
    logic [`CPU_REG_W-1:0]  field_rt;      // R-format only
    logic [`CPU_REG_W-1:0]  field_rd_r;    // rd of R-format
    logic [`CPU_REG_W-1:0]  field_rd_i;    // rd of I-format, same bits as rt
    logic [`CPU_REG_W-1:0]  rd_sel;
    logic [`CPU_REG_W-1:0]  rx, ry, ro;
    logic [`CPU_DATA_W-1:0] vx, vy;
    logic [`CPU_DATA_W-1:0] imm16;
    logic [`CPU_DATA_W-1:0] tgt_rel;

    assign imm5       = instr[4:0];
    assign imm8       = instr[7:0];
    assign disp11     = instr[10:0];
    assign field_rs   = instr[10:8];
    assign field_rt   = instr[7:5];
    assign field_rd_r = instr[4:2];
    assign field_rd_i = instr[7:5];

    assign cbus.opcode = opcode_e'(instr[15:11]);
    assign cbus.op_ext = instr[1:0];

    control u_control (
        .bus (cbus.ctl)
    );

    always_comb begin
        case (cbus.ctrl.immcode)
            IMM_ZIMM5: imm16 = {{(`CPU_DATA_W-5){1'b0}}, imm5};
            IMM_SIMM5: imm16 = {{(`CPU_DATA_W-5){imm5[4]}}, imm5};
            IMM_ZIMM8: imm16 = {{(`CPU_DATA_W-8){1'b0}}, imm8};
            IMM_SIMM8: imm16 = {{(`CPU_DATA_W-8){imm8[7]}}, imm8};
            default:   imm16 = {{(`CPU_DATA_W-11){disp11[10]}}, disp11}; // displ
        endcase
    end

    // register selection
    assign rd_sel = cbus.ctrl.instr_rformat ? field_rd_r : field_rd_i;
    assign rx     = field_rs;
    assign ry     = cbus.ctrl.readfrom_rd ? rd_sel : field_rt;
    assign ro     = cbus.ctrl.link       ? `CPU_REG_W'(`CPU_NREGS - 1) : // r7 holds the link
                    cbus.ctrl.writeto_rs ? field_rs : rd_sel;

    rf_bypassed u_rf (
        .clk        (clk),
        .rst        (rst),
        .write_en   (wb_rf_wen),
        .write_reg  (wb_ro),
        .write_data (wb_data),
        .read1_reg  (rx),
        .read2_reg  (ry),
        .read1_data (vx),
        .read2_data (vy)
    );

    assign tgt_rel = next_pc_basic + imm16; // pc-relative, wraps

    always_comb begin
        out.ctrl        = cbus.ctrl;
        out.rx          = rx;
        out.ry          = ry;
        out.ro          = ro;
        out.vx          = vx;
        out.vy          = vy;
        out.imm16       = imm16;
        out.dbranch_tgt = cbus.ctrl.siic ? `CPU_SIIC_VEC : tgt_rel; // siic acts as a jump
        out.err         = cbus.err;
    end

endmodule

`default_nettype wire

// File: decode_stage_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module decode_stage_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   if_valid,
    input  logic [`CPU_DATA_W-1:0] if_instr,
    input  logic [`CPU_DATA_W-1:0] if_next_pc,
    input  logic                   wb_rf_wen,
    input  logic [`CPU_REG_W-1:0]  wb_ro,
    input  logic [`CPU_DATA_W-1:0] wb_data,
    output logic                   ex_valid,
    output logic [3:0]             ex_alu_op,
    output logic                   ex_alu_b_imm,
    output logic [2:0]             ex_fcu_op,
    output logic [1:0]             ex_wb_op,
    output logic                   ex_writeflag,
    output logic                   ex_dmem_ren,
    output logic                   ex_dmem_wen,
    output logic                   ex_rf_wen,
    output logic [`CPU_REG_W-1:0]  ex_rx,
    output logic [`CPU_REG_W-1:0]  ex_ry,
    output logic [`CPU_REG_W-1:0]  ex_ro,
    output logic [`CPU_DATA_W-1:0] ex_vx,
    output logic [`CPU_DATA_W-1:0] ex_vy,
    output logic [`CPU_DATA_W-1:0] ex_imm16,
    output logic [1:0]             ex_flow_ty,
    output logic [`CPU_DATA_W-1:0] ex_dbranch_tgt,
    output logic                   ex_siic,
    output logic                   ex_rti,
    output logic                   ex_halt,
    output logic                   ex_err
);
    ifid_t ifid_d, ifid_q;
    logic  ifid_valid;
    idex_t idex_d, idex_q;

    assign ifid_d = '{instr: if_instr, next_pc_basic: if_next_pc};

    stage_reg #(.payload_t(ifid_t)) u_ifid (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (if_valid),
        .in_data   (ifid_d),
        .out_valid (ifid_valid),
        .out_data  (ifid_q)
    );

    decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .instr         (ifid_q.instr),
        .next_pc_basic (ifid_q.next_pc_basic),
        .wb_rf_wen     (wb_rf_wen),
        .wb_ro         (wb_ro),
        .wb_data       (wb_data),
        .out           (idex_d)
    );

    stage_reg #(.payload_t(idex_t)) u_idex (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (ifid_valid),
        .in_data   (idex_d),
        .out_valid (ex_valid),
        .out_data  (idex_q)
    );

    // flatten the bundle for execute
    assign ex_alu_op      = idex_q.ctrl.alu_op;
    assign ex_alu_b_imm   = idex_q.ctrl.alu_b_imm;
    assign ex_fcu_op      = idex_q.ctrl.fcu_op;
    assign ex_wb_op       = idex_q.ctrl.wb_op;
    assign ex_writeflag   = idex_q.ctrl.writeflag;
    assign ex_dmem_ren    = idex_q.ctrl.dmem_ren;
    assign ex_dmem_wen    = idex_q.ctrl.dmem_wen;
    assign ex_rf_wen      = idex_q.ctrl.rf_wen;
    assign ex_rx          = idex_q.rx;
    assign ex_ry          = idex_q.ry;
    assign ex_ro          = idex_q.ro;
    assign ex_vx          = idex_q.vx;
    assign ex_vy          = idex_q.vy;
    assign ex_imm16       = idex_q.imm16;
    assign ex_flow_ty     = idex_q.ctrl.flow_ty;
    assign ex_dbranch_tgt = idex_q.dbranch_tgt;
    assign ex_siic        = idex_q.ctrl.siic;
    assign ex_rti         = idex_q.ctrl.rti;
    assign ex_halt        = idex_q.ctrl.halt;
    assign ex_err         = idex_q.err;

endmodule

`default_nettype wire

// File: decode_tests.txt
// instr_npc_wben_wbro_wbdata_stall_flush_rx_ry_ro_vx_vy_imm16_tgt_ctrl_flags, all hex
// ctrl = alu[15:12] bimm[11] fcu[10:8] wb[7:6] wflag ren wen rfwen flow[1:0]; flags = siic rti halt err
0800_0010_1_3_1234_0_0_0_0_0_0000_0000_0000_0010_0000_0 // nop, fill r3
0800_0012_1_5_BEEF_0_0_0_0_0_0000_0000_0000_0012_0000_0 // nop, fill r5
439D_0020_0_0_0000_0_0_3_4_4_1234_0000_FFFD_001D_0804_0 // addi r4,r3,-3
553F_0030_1_5_5555_0_0_5_1_1_5555_0000_001F_004F_2804_0 // xori, r5 bypassed into vx
4EC5_0040_1_6_0F0F_0_0_6_6_6_0F0F_0F0F_0005_0045_1804_0 // subi r6,r6, both ports bypassed
AB44_0050_0_0_0000_0_0_3_2_2_1234_0000_0004_0054_5804_0 // slli
C280_0060_1_2_00AA_0_0_2_4_2_00AA_0000_FF80_FFE0_8804_0 // lbi simm8, writes rs
92C3_0070_0_0_0000_0_0_2_6_2_00AA_0F0F_00C3_0133_9804_0 // slbi zimm8
83BF_0080_0_0_0000_0_0_3_5_5_1234_5555_FFFF_007F_0808_0 // st, ry from rd
8EE2_0090_0_0_0000_0_0_6_7_7_0F0F_0000_0002_0092_0854_0 // ld
DD65_00A0_0_0_0000_0_0_5_3_1_5555_1234_0005_00A5_1004_0 // sub R-format
D643_00B0_0_0_0000_0_0_6_2_0_0F0F_00AA_0003_00B3_7004_0 // srl R-format
E950_00C0_1_1_8001_0_0_1_2_4_8001_00AA_0010_00D0_01E4_0 // slt, r1 bypassed
69F0_0100_0_0_0000_0_0_1_7_7_8001_0000_FFF0_00F0_0501_0 // bnez back
7D7F_0200_0_0_0000_0_0_5_3_3_5555_1234_007F_027F_0701_0 // bgez forward
27FE_0300_0_0_0000_0_0_7_7_7_0000_0000_FFFE_02FE_0002_0 // j displ -2
3155_0400_0_0_0000_0_0_1_2_7_8001_00AA_0155_0555_0086_0 // jal, ro is r7
3B04_0500_0_0_0000_0_0_3_0_7_1234_0000_0004_0504_0887_0 // jalr
2EFF_0600_0_0_0000_0_0_6_7_7_0F0F_0000_FFFF_05FF_0803_0 // jr
1003_0700_0_0_0000_0_0_0_0_0_0000_0000_0003_0002_0002_8 // siic, vector target
1800_0800_0_0_0000_0_0_0_0_0_0000_0000_0000_0800_0000_4 // rti
0000_0900_0_0_0000_0_0_0_0_0_0000_0000_0000_0900_0000_2 // halt
9A60_0A00_0_0_0000_0_0_2_3_3_00AA_1234_0000_0A00_0000_1 // illegal opcode
5810_0B00_0_0_0000_0_0_0_0_0_0000_0000_0010_0B10_3804_0 // andni zimm5
439D_0C00_0_0_0000_1_0_3_4_4_1234_0000_FFFD_0BFD_0804_0 // addi then stall
AB44_0D00_0_0_0000_0_1_3_2_2_1234_00AA_0004_0D04_5804_0 // slli then flush
FFFF_FFFF_F_F_FFFF_F_F_F_F_F_FFFF_FFFF_FFFF_FFFF_FFFF_F // end marker

// File: files.f
+incdir+.
cpu_pkg.sv
ctrl_if.sv
control.sv
rf_bypassed.sv
decode.sv
stage_reg.sv
decode_stage_top.sv
tb_decode_stage.sv

// File: rf_bypassed.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module rf_bypassed (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   write_en,
    input  logic [`CPU_REG_W-1:0]  write_reg,
    input  logic [`CPU_DATA_W-1:0] write_data,
    input  logic [`CPU_REG_W-1:0]  read1_reg,
    input  logic [`CPU_REG_W-1:0]  read2_reg,
    output logic [`CPU_DATA_W-1:0] read1_data,
    output logic [`CPU_DATA_W-1:0] read2_data
);
    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
    logic                   hit1;
    logic                   hit2;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_reg] <= write_data;
        end
    end

    // writeback lands at the end of this cycle, forward it so decode
    // sees the new value without waiting a cycle
    assign hit1 = write_en && (write_reg == read1_reg);
    assign hit2 = write_en && (write_reg == read2_reg);

    assign read1_data = hit1 ? write_data : regs[read1_reg];
    assign read2_data = hit2 ? write_data : regs[read2_reg];

endmodule

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin // flush wins over stall
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (!stall) begin
            out_valid <= in_valid;
            out_data  <= in_valid ? in_data : '0; // bubbles carry no controls
        end
    end

endmodule

`default_nettype wire

// File: tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    localparam int MAX_TESTS       = 64;
    localparam int RST_CYCLES      = 10;
    localparam int CYCLES_PER_TEST = 40; // worst case is about a dozen
    localparam int STALL_CYCLES    = 3;

    // one line of decode_tests.txt with every field a whole number of hex digits
    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] npc;
        logic [3:0]  wb_en;   // writeback during the decode cycle
        logic [3:0]  wb_ro;
        logic [15:0] wb_data;
        logic [3:0]  stall;   // hold the stage for a few cycles after the check
        logic [3:0]  flush;   // flush right after the check
        logic [3:0]  rx;
        logic [3:0]  ry;
        logic [3:0]  ro;
        logic [15:0] vx;
        logic [15:0] vy;
        logic [15:0] imm16;
        logic [15:0] tgt;
        logic [15:0] ctrl;    // alu,bimm,fcu,wb,wflag,ren,wen,rfwen,flow
        logic [3:0]  flags;   // siic,rti,halt,err
    } vec_t;

    localparam logic [159:0] END_MARK = '1; // last line of the tests file

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        if_valid;
    logic [15:0] if_instr;
    logic [15:0] if_next_pc;
    logic        wb_rf_wen;
    logic [2:0]  wb_ro;
    logic [15:0] wb_data;
    logic        ex_valid;
    logic [3:0]  ex_alu_op;
    logic        ex_alu_b_imm;
    logic [2:0]  ex_fcu_op;
    logic [1:0]  ex_wb_op;
    logic        ex_writeflag;
    logic        ex_dmem_ren;
    logic        ex_dmem_wen;
    logic        ex_rf_wen;
    logic [2:0]  ex_rx;
    logic [2:0]  ex_ry;
    logic [2:0]  ex_ro;
    logic [15:0] ex_vx;
    logic [15:0] ex_vy;
    logic [15:0] ex_imm16;
    logic [1:0]  ex_flow_ty;
    logic [15:0] ex_dbranch_tgt;
    logic        ex_siic;
    logic        ex_rti;
    logic        ex_halt;
    logic        ex_err;

    logic [159:0] tests [MAX_TESTS];
    int           n_tests;
    int           cur_test;    // 0 while checking the reset state
    int           cycles;
    int           cycle_limit; // stays 0 until the vectors are counted

    decode_stage_top UUT (.*); // port names match the signals above

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run still going after %0d clock cycles", cycles);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: test %0d, %s is %h, expected %h",
                     $time, cur_test, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_outputs(input vec_t v, input logic valid_exp);
        check("ex_valid", ex_valid, valid_exp);
        check("ex_rx", ex_rx, v.rx);
        check("ex_ry", ex_ry, v.ry);
        check("ex_ro", ex_ro, v.ro);
        check("ex_vx", ex_vx, v.vx);
        check("ex_vy", ex_vy, v.vy);
        check("ex_imm16", ex_imm16, v.imm16);
        check("ex_dbranch_tgt", ex_dbranch_tgt, v.tgt);
        check("ex_alu_op", ex_alu_op, v.ctrl[15:12]);
        check("ex_alu_b_imm", ex_alu_b_imm, v.ctrl[11]);
        check("ex_fcu_op", ex_fcu_op, v.ctrl[10:8]);
        check("ex_wb_op", ex_wb_op, v.ctrl[7:6]);
        check("ex_writeflag", ex_writeflag, v.ctrl[5]);
        check("ex_dmem_ren", ex_dmem_ren, v.ctrl[4]);
        check("ex_dmem_wen", ex_dmem_wen, v.ctrl[3]);
        check("ex_rf_wen", ex_rf_wen, v.ctrl[2]);
        check("ex_flow_ty", ex_flow_ty, v.ctrl[1:0]);
        check("ex_siic", ex_siic, v.flags[3]);
        check("ex_rti", ex_rti, v.flags[2]);
        check("ex_halt", ex_halt, v.flags[1]);
        check("ex_err", ex_err, v.flags[0]);
    endtask

    // junk instruction at the input must not move anything
    task automatic hold_under_stall(input vec_t v);
        vec_t empty;
        empty      = '0;
        stall      = 1'b1;
        if_valid   = 1'b1;
        if_instr   = 16'hFFFF;
        if_next_pc = 16'h1111;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_outputs(v, 1'b1);
        end
        stall    = 1'b0;
        if_valid = 1'b0;
        @(negedge clk);
        check_outputs(empty, 1'b0); // only the bubble held in IF/ID moves on
    endtask

    // a second copy of the vector waits in IF/ID when the flush starts
    task automatic flush_and_check(input vec_t v);
        vec_t empty;
        empty      = '0;
        flush      = 1'b1;
        if_valid   = 1'b1; // offered during the flush and must be dropped
        if_instr   = v.instr;
        if_next_pc = v.npc;
        @(negedge clk);
        flush    = 1'b0;
        if_valid = 1'b0;
        check_outputs(empty, 1'b0);
        @(negedge clk);
        check_outputs(empty, 1'b0);
    endtask

    task automatic run_test(input vec_t v);
        int gap;
        gap = $urandom % 4; // idle cycles between vectors
        repeat (gap) @(negedge clk);
        @(negedge clk);
        if_valid   = 1'b1;
        if_instr   = v.instr;
        if_next_pc = v.npc;
        @(negedge clk);      // instruction sits in IF/ID for the decode cycle
        if_valid   = v.flush[0]; // flush test queues the copy behind it
        wb_rf_wen  = v.wb_en[0];
        wb_ro      = v.wb_ro[2:0];
        wb_data    = v.wb_data;
        @(negedge clk);      // two edges after the vector
        if_valid   = 1'b0;
        wb_rf_wen  = 1'b0;
        wb_ro      = '0;
        wb_data    = '0;
        check_outputs(v, 1'b1);
        if (v.stall[0]) begin
            hold_under_stall(v);
        end
        if (v.flush[0]) begin
            flush_and_check(v);
        end
    endtask

    initial begin
        int unsigned seed_draw;
        vec_t        v;
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        if_valid    = 1'b0;
        if_instr    = '0;
        if_next_pc  = '0;
        wb_rf_wen   = 1'b0;
        wb_ro       = '0;
        wb_data     = '0;
        cycles      = 0;
        cycle_limit = 0;
        cur_test    = 0;
        seed_draw   = $urandom(32'h7789_a6dc); // seeds the generator once

        $readmemh("decode_tests.txt", tests);
        n_tests = 0;
        while (n_tests < MAX_TESTS && tests[n_tests] !== END_MARK) begin
            n_tests++;
        end
        if (n_tests == 0 || n_tests == MAX_TESTS) begin
            $display("decode_tests.txt is missing, empty or has no end marker line");
            fail_run();
        end
        cycle_limit = RST_CYCLES + CYCLES_PER_TEST * n_tests;

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        v   = '0;
        check_outputs(v, 1'b0); // empty bundle straight out of reset

        for (int i = 0; i < n_tests; i++) begin
            cur_test = i + 1;
            v        = tests[i];
            run_test(v);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
